//--- build.f
rtl/rv_isa_pkg.sv
rtl/axi_lite_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_axi_master.sv
rtl/rv_core_top.sv
verif/axi_lite_mem.sv
verif/tb_rv_core.sv

//--- rtl/axi_lite_pkg.sv
package axi_lite_pkg;

  // xresp encodings
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_exokay = 2'b01;
  localparam logic [1:0] resp_slverr = 2'b10;
  localparam logic [1:0] resp_decerr = 2'b11;

  // axprot bits
  //   [0] privileged
  //   [1] non-secure
  //   [2] instruction
  localparam logic [2:0] prot_instr = 3'b101;  // privileged, secure, instruction
  localparam logic [2:0] prot_data  = 3'b001;  // privileged, secure, data

endpackage

//--- rtl/rv_axi_master.sv
`timescale 1ns/1ns

module rv_axi_master (
  input  logic        clk,
  input  logic        reset,
  input  logic        req,
  input  logic        req_write,
  input  logic [31:0] req_addr,
  input  logic [2:0]  req_prot,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_wstrb,
  output logic        done,
  output logic        done_err,
  output logic [31:0] done_rdata,
  output logic        awvalid,
  input  logic        awready,
  output logic [31:0] awaddr,
  output logic [2:0]  awprot,
  output logic        wvalid,
  input  logic        wready,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  input  logic        bvalid,
  output logic        bready,
  input  logic [1:0]  bresp,
  output logic        arvalid,
  input  logic        arready,
  output logic [31:0] araddr,
  output logic [2:0]  arprot,
  input  logic        rvalid,
  output logic        rready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_read  = 2'd1;
  localparam logic [1:0] st_write = 2'd2;

  logic [1:0] state;
  logic       aw_ok;  // aw beat done or going now
  logic       w_ok;

  assign aw_ok = !awvalid || awready;
  assign w_ok  = !wvalid || wready;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state   <= st_idle;
      done    <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: if (req) begin
          if (req_write) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= st_write;
          end else begin
            arvalid <= 1'b1;
            state   <= st_read;
          end
        end
        st_read: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end
          if (rready && rvalid) begin
            rready <= 1'b0;
            done   <= 1'b1;
            state  <= st_idle;
          end
        end
        st_write: begin
          if (awvalid && awready)
            awvalid <= 1'b0;
          if (wvalid && wready)
            wvalid <= 1'b0;
          if (!bready && aw_ok && w_ok)
            bready <= 1'b1;   // both address and data accepted
          if (bready && bvalid) begin
            bready <= 1'b0;
            done   <= 1'b1;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payloads only load while idle, so they stay put under valid
  always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
      araddr <= req_addr;
      arprot <= req_prot;
      awaddr <= req_addr;
      awprot <= req_prot;
      wdata  <= req_wdata;
      wstrb  <= req_wstrb;
    end
    if (state == st_read && rready && rvalid) begin
      done_rdata <= rdata;
      done_err   <= !(rresp == axi_lite_pkg::resp_okay || rresp == axi_lite_pkg::resp_exokay);
    end else if (state == st_write && bready && bvalid) begin
      done_err <= !(bresp == axi_lite_pkg::resp_okay || bresp == axi_lite_pkg::resp_exokay);
    end
  end

  // a valid only drops after its handshake
  assert property (@(posedge clk) disable iff (!reset) $fell(arvalid) |-> $past(arready));
  assert property (@(posedge clk) disable iff (!reset) $fell(awvalid) |-> $past(awready));
  assert property (@(posedge clk) disable iff (!reset) $fell(wvalid) |-> $past(wready));

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                   clk,
  input  logic                   reset,
  output logic                   awvalid,
  input  logic                   awready,
  output logic [31:0]            awaddr,
  output logic [2:0]             awprot,
  output logic                   wvalid,
  input  logic                   wready,
  output logic [31:0]            wdata,
  output logic [3:0]             wstrb,
  input  logic                   bvalid,
  output logic                   bready,
  input  logic [1:0]             bresp,
  output logic                   arvalid,
  input  logic                   arready,
  output logic [31:0]            araddr,
  output logic [2:0]             arprot,
  input  logic                   rvalid,
  output logic                   rready,
  input  logic [31:0]            rdata,
  input  logic [1:0]             rresp,
  output logic                   trap,
  output rv_isa_pkg::trap_code_t trap_code
);

  rv_isa_pkg::instr_u  instr;
  rv_isa_pkg::mem_op_t op;
  logic [2:0]          width;
  logic [4:0]          rd;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [31:0]         imm;
  logic                illegal;
  logic [31:0]         rs1_data;
  logic [31:0]         rs2_data;
  logic                req;
  logic                req_write;
  logic [31:0]         req_addr;
  logic [2:0]          req_prot;
  logic [31:0]         req_wdata;
  logic [3:0]          req_wstrb;
  logic                done;
  logic                done_err;
  logic [31:0]         done_rdata;
  logic                wb;
  logic [1:0]          wb_offset;

  rv_decode rv_decode_inst (
    .instr(instr), .op(op), .width(width), .rd(rd), .rs1(rs1), .rs2(rs2),
    .imm(imm), .illegal(illegal)
  );

  rv_execute #(.reset_pc(reset_pc)) rv_execute_inst (
    .clk(clk), .reset(reset), .op(op), .width(width), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .imm(imm), .illegal(illegal), .req(req), .req_write(req_write),
    .req_addr(req_addr), .req_prot(req_prot), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
    .done(done), .done_err(done_err), .done_rdata(done_rdata), .wb(wb),
    .wb_offset(wb_offset), .instr(instr), .trap(trap), .trap_code(trap_code)
  );

  // load data comes straight from the bus master
  rv_result rv_result_inst (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .width(width),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb), .wb_offset(wb_offset),
    .wb_rdata(done_rdata)
  );

  rv_axi_master rv_axi_master_inst (
    .clk(clk), .reset(reset), .req(req), .req_write(req_write), .req_addr(req_addr),
    .req_prot(req_prot), .req_wdata(req_wdata), .req_wstrb(req_wstrb), .done(done),
    .done_err(done_err), .done_rdata(done_rdata), .awvalid(awvalid), .awready(awready),
    .awaddr(awaddr), .awprot(awprot), .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .wstrb(wstrb), .bvalid(bvalid), .bready(bready), .bresp(bresp), .arvalid(arvalid),
    .arready(arready), .araddr(araddr), .arprot(arprot), .rvalid(rvalid),
    .rready(rready), .rdata(rdata), .rresp(rresp)
  );

endmodule

//--- rtl/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
  input  rv_isa_pkg::instr_u  instr,
  output rv_isa_pkg::mem_op_t op,
  output logic [2:0]          width,
  output logic [4:0]          rd,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [31:0]         imm,
  output logic                illegal
);

  always_comb begin
    op      = rv_isa_pkg::mem_none;
    width   = instr.i_type.funct3;
    rd      = 5'd0;
    rs1     = instr.i_type.rs1;
    rs2     = 5'd0;
    imm     = 32'd0;
    illegal = 1'b1;   // anything not matched below

    case (instr.i_type.opcode)
      rv_isa_pkg::op_load: begin
        op  = rv_isa_pkg::mem_load;
        rd  = instr.i_type.rd;
        imm = {{20{instr.i_type.imm[11]}}, instr.i_type.imm};
        case (instr.i_type.funct3)
          rv_isa_pkg::f3_byte,
          rv_isa_pkg::f3_half,
          rv_isa_pkg::f3_word,
          rv_isa_pkg::f3_byte_u,
          rv_isa_pkg::f3_half_u: illegal = (instr.i_type.rd == 5'd0); // no load into x0
          default:               illegal = 1'b1;
        endcase
      end

      rv_isa_pkg::op_store: begin
        op    = rv_isa_pkg::mem_store;
        width = instr.s_type.funct3;
        rs1   = instr.s_type.rs1;
        rs2   = instr.s_type.rs2;
        imm   = {{20{instr.s_type.imm_hi[6]}}, instr.s_type.imm_hi, instr.s_type.imm_lo};
        case (instr.s_type.funct3)
          rv_isa_pkg::f3_byte,
          rv_isa_pkg::f3_half,
          rv_isa_pkg::f3_word: illegal = 1'b0;
          default:             illegal = 1'b1; // no unsigned stores
        endcase
      end

      default: ;
    endcase

    if (illegal)
      op = rv_isa_pkg::mem_none;
  end

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ns

module rv_execute #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  rv_isa_pkg::mem_op_t    op,
  input  logic [2:0]             width,
  input  logic [31:0]            rs1_data,
  input  logic [31:0]            rs2_data,
  input  logic [31:0]            imm,
  input  logic                   illegal,
  output logic                   req,
  output logic                   req_write,
  output logic [31:0]            req_addr,
  output logic [2:0]             req_prot,
  output logic [31:0]            req_wdata,
  output logic [3:0]             req_wstrb,
  input  logic                   done,
  input  logic                   done_err,
  input  logic [31:0]            done_rdata,
  output logic                   wb,
  output logic [1:0]             wb_offset,
  output rv_isa_pkg::instr_u     instr,
  output logic                   trap,
  output rv_isa_pkg::trap_code_t trap_code
);

  localparam logic [2:0] st_fetch      = 3'd0;
  localparam logic [2:0] st_wait_fetch = 3'd1;
  localparam logic [2:0] st_exec       = 3'd2;
  localparam logic [2:0] st_wait_mem   = 3'd3;
  localparam logic [2:0] st_halt       = 3'd4;

  logic [2:0]  state;
  logic [31:0] pc;
  logic [31:0] addr;
  logic        is_half;
  logic        is_word;
  logic        misaligned;
  logic [3:0]  strb_base;
  logic        issue_fetch;
  logic        issue_mem;

  assign addr       = rs1_data + imm;
  assign is_half    = (width == rv_isa_pkg::f3_half) || (width == rv_isa_pkg::f3_half_u);
  assign is_word    = (width == rv_isa_pkg::f3_word);
  assign misaligned = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

  always_comb begin
    case (width)
      rv_isa_pkg::f3_byte: strb_base = 4'b0001;
      rv_isa_pkg::f3_half: strb_base = 4'b0011;
      default:             strb_base = 4'b1111;
    endcase
  end

  assign issue_fetch = (state == st_fetch);
  assign issue_mem   = (state == st_exec) && !illegal && !misaligned;

  // load data goes straight into the register file on done
  assign wb = (state == st_wait_mem) && done && !done_err && (op == rv_isa_pkg::mem_load);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state     <= st_fetch;
      pc        <= reset_pc;
      req       <= 1'b0;
      trap      <= 1'b0;
      trap_code <= rv_isa_pkg::trap_mem;
    end else begin
      req <= issue_fetch || issue_mem;
      case (state)
        st_fetch: state <= st_wait_fetch;
        st_wait_fetch: if (done) begin
          if (done_err) begin
            trap      <= 1'b1;
            trap_code <= rv_isa_pkg::trap_mem;
            state     <= st_halt;
          end else begin
            state <= st_exec;
          end
        end
        st_exec: begin
          if (illegal) begin
            trap      <= 1'b1;
            trap_code <= rv_isa_pkg::trap_illegal;
            state     <= st_halt;
          end else if (misaligned) begin
            trap      <= 1'b1;
            trap_code <= rv_isa_pkg::trap_misaligned;
            state     <= st_halt;
          end else begin
            state <= st_wait_mem;
          end
        end
        st_wait_mem: if (done) begin
          if (done_err) begin
            trap      <= 1'b1;
            trap_code <= rv_isa_pkg::trap_mem;
            state     <= st_halt;
          end else begin
            pc    <= pc + 32'd4;
            state <= st_fetch;
          end
        end
        default: ;  // halt until reset
      endcase
    end
  end

  // request payload and instruction word
  always_ff @(posedge clk) begin
    if (issue_fetch) begin
      req_write <= 1'b0;
      req_addr  <= pc;
      req_prot  <= axi_lite_pkg::prot_instr;
    end else if (issue_mem) begin
      req_write <= (op == rv_isa_pkg::mem_store);
      req_addr  <= addr;
      req_prot  <= axi_lite_pkg::prot_data;
      req_wdata <= rs2_data << {addr[1:0], 3'b000};  // into byte lane
      req_wstrb <= strb_base << addr[1:0];
      wb_offset <= addr[1:0];
    end
    if (state == st_wait_fetch && done && !done_err)
      instr <= done_rdata;
  end

  // every request is followed by a wait for its done, never by a trap
  assert property (@(posedge clk) disable iff (!reset)
    req |-> (state == st_wait_fetch || state == st_wait_mem) && !trap);

  // sticky trap, code frozen with it
  assert property (@(posedge clk) disable iff (!reset) trap |=> trap && $stable(trap_code));

endmodule

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // one instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_type;       // loads
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_type;       // stores
  } instr_u;

  // major opcodes
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  // funct3 width codes
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef enum logic [1:0] {
    trap_mem        = 2'b00, // bad bus response
    trap_illegal    = 2'b01,
    trap_misaligned = 2'b10
  } trap_code_t;

  typedef enum logic [1:0] {
    mem_none  = 2'b00,
    mem_load  = 2'b01,
    mem_store = 2'b10
  } mem_op_t;

endpackage

//--- rtl/rv_result.sv
`timescale 1ns/1ns

module rv_result (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [2:0]  width,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        wb,
  input  logic [1:0]  wb_offset,
  input  logic [31:0] wb_rdata
);

  logic [31:0] regs [1:31];   // x0 is not stored
  logic [31:0] shifted;
  logic [31:0] wb_value;

  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  // move the addressed lane down to bit 0
  assign shifted = wb_rdata >> {wb_offset, 3'b000};

  always_comb begin
    case (width)
      rv_isa_pkg::f3_byte:   wb_value = {{24{shifted[7]}}, shifted[7:0]};
      rv_isa_pkg::f3_byte_u: wb_value = {24'd0, shifted[7:0]};
      rv_isa_pkg::f3_half:   wb_value = {{16{shifted[15]}}, shifted[15:0]};
      rv_isa_pkg::f3_half_u: wb_value = {16'd0, shifted[15:0]};
      default:               wb_value = shifted;  // lw
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= 32'd0;
    end else if (wb && (rd != 5'd0)) begin
      regs[rd] <= wb_value;
    end
  end

  // decode flags loads to x0 as illegal, so no write-back ever targets it
  assert property (@(posedge clk) disable iff (!reset) wb |-> (rd != 5'd0));

endmodule

//--- run.sh
#!/bin/bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_rv_core -o sim_tb_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb_rv_core > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

//--- verif/axi_lite_mem.sv
`timescale 1ns/1ns

module axi_lite_mem (
  input  logic        clk,
  input  logic        reset,
  input  logic        err_en,     // answer a read of err_addr with SLVERR
  input  logic [31:0] err_addr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp
);

  logic [31:0] mem [0:1023];  // 4 KiB, word addressed
  integer      seed;

  logic        rst_s, ar_s, aw_s, w_s, ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic [31:0] ar_a, aw_a, w_d, rd_a, wr_a, wr_d;
  logic [3:0]  w_s_strb, wr_s;
  logic        rd_pend, aw_got, w_got;
  int          ar_cnt, rd_cnt, aw_cnt, w_cnt;

  initial begin
    seed    = 32'he9e;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = axi_lite_pkg::resp_okay;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = 32'd0;
    rresp   = axi_lite_pkg::resp_okay;
    rd_pend = 1'b0;
    aw_got  = 1'b0;
    w_got   = 1'b0;
    ar_cnt  = 0;
    rd_cnt  = 0;
    aw_cnt  = 0;
    w_cnt   = 0;
    forever begin
      // sample handshakes mid-cycle where everything is stable
      @(negedge clk);
      rst_s    = reset;
      ar_s     = arvalid;
      aw_s     = awvalid;
      w_s      = wvalid;
      ar_hs    = arvalid && arready;
      r_hs     = rvalid && rready;
      aw_hs    = awvalid && awready;
      w_hs     = wvalid && wready;
      b_hs     = bvalid && bready;
      ar_a     = araddr;
      aw_a     = awaddr;
      w_d      = wdata;
      w_s_strb = wstrb;
      @(posedge clk);
      #1;
      if (!rst_s) begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rd_pend = 1'b0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
      end else begin
        // read side
        if (r_hs)
          rvalid = 1'b0;
        if (ar_hs) begin
          arready = 1'b0;
          rd_pend = 1'b1;
          rd_a    = ar_a;
          rd_cnt  = {$random(seed)} % 4;
          ar_cnt  = {$random(seed)} % 4;
        end else if (ar_s && !arready && !rd_pend && !rvalid) begin
          if (ar_cnt == 0)
            arready = 1'b1;
          else
            ar_cnt--;
        end
        if (rd_pend) begin
          if (rd_cnt == 0) begin
            rvalid  = 1'b1;
            rdata   = mem[rd_a[11:2]];
            rresp   = (err_en && rd_a == err_addr) ? axi_lite_pkg::resp_slverr
                                                   : axi_lite_pkg::resp_okay;
            rd_pend = 1'b0;
          end else begin
            rd_cnt--;
          end
        end
        // write side, aw and w accepted independently
        if (b_hs)
          bvalid = 1'b0;
        if (aw_hs) begin
          awready = 1'b0;
          aw_got  = 1'b1;
          wr_a    = aw_a;
          aw_cnt  = {$random(seed)} % 4;
        end else if (aw_s && !awready && !aw_got) begin
          if (aw_cnt == 0)
            awready = 1'b1;
          else
            aw_cnt--;
        end
        if (w_hs) begin
          wready = 1'b0;
          w_got  = 1'b1;
          wr_d   = w_d;
          wr_s   = w_s_strb;
          w_cnt  = {$random(seed)} % 4;
        end else if (w_s && !wready && !w_got) begin
          if (w_cnt == 0)
            wready = 1'b1;
          else
            w_cnt--;
        end
        if (aw_got && w_got && !bvalid) begin
          for (int b = 0; b < 4; b++)
            if (wr_s[b])
              mem[wr_a[11:2]][8*b +: 8] = wr_d[8*b +: 8];
          bvalid = 1'b1;
          bresp  = axi_lite_pkg::resp_okay;
          aw_got = 1'b0;
          w_got  = 1'b0;
        end
      end
    end
  end

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

  logic        clk;
  logic        reset;
  logic        err_en;
  logic [31:0] err_addr;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [2:0]  awprot, arprot;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        trap;
  rv_isa_pkg::trap_code_t trap_code;

  integer      seed;
  logic [31:0] prog [$];
  logic [31:0] ref_mem [0:1023];
  logic [31:0] ref_regs [0:31];
  logic [31:0] ref_pc;
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  logic [3:0]  exp_strb_q [$];
  logic [31:0] exp_raddr_q [$];
  logic [2:0]  exp_rprot_q [$];
  logic [1:0]  exp_code;
  int          exp_stores;
  int          stores_seen;
  int          exp_reads;
  int          reads_seen;
  int          errors;
  longint      deadline;
  logic        got_aw, got_w;
  logic [31:0] cap_addr, cap_data;
  logic [2:0]  cap_prot;
  logic [3:0]  cap_strb;

  rv_core_top #(.reset_pc(32'h0)) rv_core_top_inst (
    .clk(clk), .reset(reset), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .awprot(awprot), .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp), .arvalid(arvalid),
    .arready(arready), .araddr(araddr), .arprot(arprot), .rvalid(rvalid),
    .rready(rready), .rdata(rdata), .rresp(rresp), .trap(trap), .trap_code(trap_code)
  );

  axi_lite_mem mem_inst (
    .clk(clk), .reset(reset), .err_en(err_en), .err_addr(err_addr),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .wvalid(wvalid),
    .wready(wready), .wdata(wdata), .wstrb(wstrb), .bvalid(bvalid), .bready(bready),
    .bresp(bresp), .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  // architectural model, one instruction per call, returns 1 on a trap
  function automatic bit ref_step(output bit st, output logic [31:0] a,
                                  output logic [31:0] d, output logic [3:0] s,
                                  output logic [1:0] code);
    logic [31:0] w, imm, word;
    logic [2:0]  f3;
    logic [4:0]  rd, rs1, rs2;
    logic [1:0]  off;
    bit          mis;
    w    = ref_mem[ref_pc[11:2]];
    exp_raddr_q.push_back(ref_pc);  // instruction fetch
    exp_rprot_q.push_back(axi_lite_pkg::prot_instr);
    f3   = w[14:12];
    rd   = w[11:7];
    rs1  = w[19:15];
    rs2  = w[24:20];
    st   = 1'b0;
    a    = 32'd0;
    d    = 32'd0;
    s    = 4'd0;
    code = rv_isa_pkg::trap_illegal;
    if (w[6:0] == 7'b0000011) begin
      if (!(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd5) || rd == 0)
        return 1'b1;
      imm = {{20{w[31]}}, w[31:20]};
    end else if (w[6:0] == 7'b0100011) begin
      if (f3 > 3'd2)
        return 1'b1;
      imm = {{20{w[31]}}, w[31:25], w[11:7]};
    end else begin
      return 1'b1;
    end
    a    = ref_regs[rs1] + imm;
    off  = a[1:0];
    mis  = (f3[1:0] == 2'd1 && a[0]) || (f3[1:0] == 2'd2 && off != 2'd0);
    code = rv_isa_pkg::trap_misaligned;
    if (mis)
      return 1'b1;
    if (w[6:0] == 7'b0000011) begin
      exp_raddr_q.push_back(a);  // data read, also when it errors
      exp_rprot_q.push_back(axi_lite_pkg::prot_data);
      code = rv_isa_pkg::trap_mem;
      if (err_en && a == err_addr)
        return 1'b1;
      word = ref_mem[a[11:2]] >> (8 * off);
      case (f3)
        3'd0:    ref_regs[rd] = {{24{word[7]}}, word[7:0]};
        3'd4:    ref_regs[rd] = {24'd0, word[7:0]};
        3'd1:    ref_regs[rd] = {{16{word[15]}}, word[15:0]};
        3'd5:    ref_regs[rd] = {16'd0, word[15:0]};
        default: ref_regs[rd] = word;
      endcase
    end else begin
      st = 1'b1;
      d  = ref_regs[rs2] << (8 * off);
      s  = ((f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111) << off;
      for (int b = 0; b < 4; b++)
        if (s[b])
          ref_mem[a[11:2]][8*b +: 8] = d[8*b +: 8];
    end
    ref_pc = ref_pc + 32'd4;
    return 1'b0;
  endfunction

  task automatic run_test(input logic [31:0] fail_addr, input logic fail_en);
    bit          st, trapped;
    logic [31:0] a, d;
    logic [3:0]  s;
    int          steps;
    @(posedge clk);
    #1 reset = 1'b0;
    err_en   = fail_en;
    err_addr = fail_addr;
    for (int i = 0; i < 1024; i++) begin
      if (i < 256)
        mem_inst.mem[i] = (i < prog.size()) ? prog[i] : 32'd0;
      else
        mem_inst.mem[i] = $random(seed);
    end
    mem_inst.mem[256] = 32'h0000_0580;  // base pointer
    mem_inst.mem[258] = 32'h80ff_7f01;  // every sign case
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = mem_inst.mem[i];
    for (int r = 0; r < 32; r++)
      ref_regs[r] = 32'd0;
    ref_pc = 32'd0;
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_strb_q.delete();
    exp_raddr_q.delete();
    exp_rprot_q.delete();
    steps   = 0;
    trapped = 1'b0;
    while (!trapped && steps < 250) begin
      trapped = ref_step(st, a, d, s, exp_code);
      if (st) begin
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
        exp_strb_q.push_back(s);
      end
      steps++;
    end
    exp_stores  = exp_addr_q.size();
    stores_seen = 0;
    exp_reads   = exp_raddr_q.size();
    reads_seen  = 0;
    repeat (8) @(posedge clk);
    deadline = $time + longint'(steps + 2) * 60 * 10;  // 60 cycles worst case each
    #1 reset = 1'b1;
    while (!trap)
      @(negedge clk);
    repeat (20) @(negedge clk);  // no bus activity may follow
    check("trap", trap, 1);
    check("trap_code", trap_code, exp_code);
    check("store_count", stores_seen, exp_stores);
    check("read_count", reads_seen, exp_reads);
  endtask

  // bus monitor and comparison
  initial begin
    got_aw = 1'b0;
    got_w  = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        got_aw = 1'b0;
        got_w  = 1'b0;
      end else begin
        if (trap && (arvalid || awvalid))
          abort_run("bus request issued after trap");
        if (arvalid && arready) begin
          if (exp_raddr_q.size() == 0)
            abort_run("read seen that the model does not expect");
          check("araddr", araddr, exp_raddr_q.pop_front());
          check("arprot", arprot, exp_rprot_q.pop_front());
          reads_seen++;
        end
        if (awvalid && awready) begin
          got_aw   = 1'b1;
          cap_addr = awaddr;
          cap_prot = awprot;
        end
        if (wvalid && wready) begin
          got_w    = 1'b1;
          cap_data = wdata;
          cap_strb = wstrb;
        end
        if (got_aw && got_w) begin
          got_aw = 1'b0;
          got_w  = 1'b0;
          if (exp_addr_q.size() == 0)
            abort_run("store seen that the model does not expect");
          check("awaddr", cap_addr, exp_addr_q.pop_front());
          check("wdata", cap_data, exp_data_q.pop_front());
          check("wstrb", cap_strb, exp_strb_q.pop_front());
          check("awprot", cap_prot, axi_lite_pkg::prot_data);
          stores_seen++;
        end
      end
    end
  end

  initial begin
    deadline = 5000;
    forever begin
      @(negedge clk);
      if ($time > deadline)
        abort_run("timeout, core did not reach the expected trap");
    end
  end

  initial begin
    seed     = 32'he9e;
    reset    = 1'b0;
    err_en   = 1'b0;
    err_addr = 32'd0;
    errors   = 0;
    // word loads and stores with negative offsets, sub-word loads and stores
    prog.delete();
    prog.push_back(enc_load(3'd2, 5'd1, 5'd0, 12'h400));      // x1 = 0x580
    prog.push_back(enc_load(3'd2, 5'd2, 5'd1, -12'sd16));
    prog.push_back(enc_load(3'd2, 5'd3, 5'd1, 12'd8));
    prog.push_back(enc_store(3'd2, 5'd2, 5'd1, 12'h100));
    prog.push_back(enc_store(3'd2, 5'd3, 5'd1, -12'sd128));
    for (int k = 0; k < 4; k++) begin
      prog.push_back(enc_load(3'd0, 5'd4, 5'd0, 12'h408 + k));  // lb
      prog.push_back(enc_store(3'd2, 5'd4, 5'd0, 12'h640 + 8 * k));
      prog.push_back(enc_load(3'd4, 5'd5, 5'd0, 12'h408 + k));  // lbu
      prog.push_back(enc_store(3'd2, 5'd5, 5'd0, 12'h644 + 8 * k));
    end
    for (int k = 0; k < 4; k += 2) begin
      prog.push_back(enc_load(3'd1, 5'd6, 5'd0, 12'h408 + k));  // lh
      prog.push_back(enc_store(3'd2, 5'd6, 5'd0, 12'h660 + 4 * k));
      prog.push_back(enc_load(3'd5, 5'd7, 5'd0, 12'h408 + k));  // lhu
      prog.push_back(enc_store(3'd2, 5'd7, 5'd0, 12'h664 + 4 * k));
    end
    prog.push_back(enc_load(3'd1, 5'd9, 5'd1, -12'sd6));
    prog.push_back(enc_store(3'd2, 5'd9, 5'd0, 12'h6f0));
    for (int k = 0; k < 4; k++)
      prog.push_back(enc_store(3'd0, 5'd2, 5'd0, 12'h700 + k));
    for (int k = 0; k < 4; k += 2)
      prog.push_back(enc_store(3'd1, 5'd2, 5'd0, 12'h710 + k));
    prog.push_back(enc_store(3'd2, 5'd0, 5'd0, 12'h724));        // x0 stores zero
    prog.push_back(32'h0010_0093);                               // addi, unsupported
    run_test(32'd0, 1'b0);
    // error response on a data read
    prog.delete();
    prog.push_back(enc_load(3'd2, 5'd2, 5'd0, 12'h400));
    prog.push_back(enc_load(3'd2, 5'd3, 5'd0, 12'h7f0));
    prog.push_back(enc_store(3'd2, 5'd2, 5'd0, 12'h600));
    run_test(32'h7f0, 1'b1);
    // misaligned half load
    prog.delete();
    prog.push_back(enc_load(3'd2, 5'd1, 5'd0, 12'h400));
    prog.push_back(enc_load(3'd1, 5'd2, 5'd1, 12'd1));
    prog.push_back(enc_store(3'd2, 5'd1, 5'd0, 12'h600));
    run_test(32'd0, 1'b0);
    // load into x0
    prog.delete();
    prog.push_back(enc_store(3'd2, 5'd0, 5'd0, 12'h604));
    prog.push_back(enc_load(3'd2, 5'd0, 5'd0, 12'h400));
    prog.push_back(enc_store(3'd2, 5'd0, 5'd0, 12'h608));
    run_test(32'd0, 1'b0);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
